//--- design/lsu_pkg.sv
package lsu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and memory map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int TAG_W      = 5;
    localparam int SRAM_WORDS = 256;
    localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);

    localparam logic [ADDR_W-1:0] SRAM_BASE       = 32'h8000_0000;
    // the reset window spans the whole memory.
    localparam logic [ADDR_W-1:0] WIN_RESET_BASE  = SRAM_BASE;
    localparam logic [ADDR_W-1:0] WIN_RESET_LIMIT = SRAM_BASE + SRAM_WORDS * 4 - 4;

    localparam logic WIN_SEL_BASE  = 1'b0;
    localparam logic WIN_SEL_LIMIT = 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_t;

    // the size code doubles as the bus size field (log2 of the byte count).
    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_t;

    typedef enum logic [1:0] {RESP_OKAY = 2'd0, RESP_SLVERR = 2'd2} resp_t;

    typedef enum logic [1:0] {LSU_IDLE, LSU_READ, LSU_WRITE} lsu_state_t;

    // natural alignment of an address for an access size.
    function automatic logic addr_aligned(logic [ADDR_W-1:0] addr, mem_size_t size);
        logic ok;
        case (size)
            SIZE_HALF: ok = (addr[0] == 1'b0);
            SIZE_WORD: ok = (addr[1:0] == 2'b00);
            default:   ok = 1'b1;
        endcase
        return ok;
    endfunction

endpackage

//--- design/mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if;
    import lsu_pkg::*;

    // write address and data channels.
    logic              aw_valid;
    logic              aw_ready;
    logic [ADDR_W-1:0] aw_addr;
    mem_size_t         aw_size;
    logic              w_valid;
    logic              w_ready;
    logic [DATA_W-1:0] w_data;
    logic [3:0]        w_strb;

    // write response.
    logic              b_valid;
    logic              b_ready;
    resp_t             b_resp;

    // read address and data channels.
    logic              ar_valid;
    logic              ar_ready;
    logic [ADDR_W-1:0] ar_addr;
    mem_size_t         ar_size;
    logic              r_valid;
    logic              r_ready;
    logic [DATA_W-1:0] r_data;
    resp_t             r_resp;

    modport master (
        output aw_valid, aw_addr, aw_size, w_valid, w_data, w_strb, b_ready,
        output ar_valid, ar_addr, ar_size, r_ready,
        input  aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
    );

    modport slave (
        input  aw_valid, aw_addr, aw_size, w_valid, w_data, w_strb, b_ready,
        input  ar_valid, ar_addr, ar_size, r_ready,
        output aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
    );

endinterface

//--- design/lsu.sv
`timescale 1ns/1ns

module lsu (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_valid,
    input  lsu_pkg::mem_op_t             req_op,
    input  lsu_pkg::mem_size_t           req_size,
    input  logic                         req_signed,
    input  logic [lsu_pkg::ADDR_W-1:0]   req_addr,
    input  logic [lsu_pkg::DATA_W-1:0]   req_wdata,
    input  logic [lsu_pkg::TAG_W-1:0]    req_tag,
    output logic                         lsu_ready,
    output logic                         resp_valid,
    output logic [lsu_pkg::TAG_W-1:0]    resp_tag,
    output logic [lsu_pkg::DATA_W-1:0]   resp_data,
    output logic                         resp_fault,
    mem_bus_if.master                    bus
);
    import lsu_pkg::*;

    lsu_state_t        state;
    mem_size_t         size_q;
    logic              signed_q;
    logic [1:0]        off_q;
    logic              accept;
    logic              ar_done;
    logic              r_done;
    logic              w_done;
    logic              b_done;
    logic [DATA_W-1:0] r_shifted;
    logic [DATA_W-1:0] load_data;
    logic [3:0]        store_strb;

    assign lsu_ready = (state == LSU_IDLE);
    assign accept    = req_valid && lsu_ready;

    assign ar_done = bus.ar_valid && bus.ar_ready;
    assign r_done  = bus.r_valid && bus.r_ready;
    assign w_done  = bus.aw_valid && bus.aw_ready && bus.w_valid && bus.w_ready;
    assign b_done  = bus.b_valid && bus.b_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data alignment
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (req_size)
            SIZE_BYTE: store_strb = 4'b0001 << req_addr[1:0];
            SIZE_HALF: store_strb = 4'b0011 << req_addr[1:0];
            default:   store_strb = 4'b1111;
        endcase
    end

    // the addressed lane is moved down to bit 0 before extension.
    assign r_shifted = bus.r_data >> {off_q, 3'b000};

    always_comb begin
        case (size_q)
            SIZE_BYTE: load_data = {{24{signed_q & r_shifted[7]}}, r_shifted[7:0]};
            SIZE_HALF: load_data = {{16{signed_q & r_shifted[15]}}, r_shifted[15:0]};
            default:   load_data = r_shifted;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request FSM and channel handshakes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= LSU_IDLE;
            resp_valid   <= 1'b0;
            resp_fault   <= 1'b0;
            bus.ar_valid <= 1'b0;
            bus.r_ready  <= 1'b0;
            bus.aw_valid <= 1'b0;
            bus.w_valid  <= 1'b0;
            bus.b_ready  <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                LSU_IDLE: begin
                    if (accept) begin
                        case (req_op)
                            MEM_LOAD: begin
                                bus.ar_valid <= 1'b1;
                                state        <= LSU_READ;
                            end
                            MEM_STORE: begin
                                bus.aw_valid <= 1'b1;
                                bus.w_valid  <= 1'b1;
                                state        <= LSU_WRITE;
                            end
                            default: begin
                                resp_valid <= 1'b1;
                                resp_fault <= 1'b0;
                            end
                        endcase
                    end
                end
                LSU_READ: begin
                    // the response pulse is out, so the unit frees up next cycle.
                    if (resp_valid) begin
                        state <= LSU_IDLE;
                    end
                    if (ar_done) begin
                        bus.ar_valid <= 1'b0;
                        bus.r_ready  <= 1'b1;
                    end
                    if (r_done) begin
                        bus.r_ready <= 1'b0;
                        resp_valid  <= 1'b1;
                        resp_fault  <= (bus.r_resp != RESP_OKAY);
                    end
                end
                LSU_WRITE: begin
                    if (resp_valid) begin
                        state <= LSU_IDLE;
                    end
                    if (w_done) begin
                        bus.aw_valid <= 1'b0;
                        bus.w_valid  <= 1'b0;
                        bus.b_ready  <= 1'b1;
                    end
                    if (b_done) begin
                        bus.b_ready <= 1'b0;
                        resp_valid  <= 1'b1;
                        resp_fault  <= (bus.b_resp != RESP_OKAY);
                    end
                end
                default: state <= LSU_IDLE;
            endcase
        end
    end

    // request fields and channel payloads.
    always_ff @(posedge clk) begin
        if (accept) begin
            resp_tag <= req_tag;
            size_q   <= req_size;
            signed_q <= req_signed;
            off_q    <= req_addr[1:0];
            case (req_op)
                MEM_LOAD: begin
                    bus.ar_addr <= req_addr;
                    bus.ar_size <= req_size;
                end
                MEM_STORE: begin
                    bus.aw_addr <= req_addr;
                    bus.aw_size <= req_size;
                    bus.w_data  <= req_wdata << {req_addr[1:0], 3'b000};
                    bus.w_strb  <= store_strb;
                end
                default: resp_data <= req_addr;
            endcase
        end
        if (r_done) begin
            resp_data <= load_data;
        end
        if (b_done) begin
            resp_data <= bus.aw_addr;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // assertions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_req_aligned: assert property (@(posedge clk) disable iff (rst)
        accept && (req_op != MEM_NONE) |-> addr_aligned(req_addr, req_size));

    // a read request may not be withdrawn or changed while the memory stalls it.
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        bus.ar_valid && !bus.ar_ready |=> bus.ar_valid && $stable(bus.ar_addr));

endmodule

//--- design/data_sram.sv
`timescale 1ns/1ns

module data_sram (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [lsu_pkg::ADDR_W-1:0] win_base,
    input  logic [lsu_pkg::ADDR_W-1:0] win_limit,
    mem_bus_if.slave                   bus
);
    import lsu_pkg::*;

    logic [DATA_W-1:0]     mem [SRAM_WORDS];
    logic                  wr_open;
    logic                  rd_busy;
    logic                  wr_busy;
    logic                  rd_done;
    logic                  wr_done;
    logic [ADDR_W-1:0]     rd_word;
    logic [ADDR_W-1:0]     wr_word;
    logic                  rd_ok;
    logic                  wr_ok;
    logic [SRAM_IDX_W-1:0] rd_idx;
    logic [SRAM_IDX_W-1:0] wr_idx;

    // the memory powers up cleared.
    initial begin
        for (int i = 0; i < SRAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign bus.aw_ready = wr_open;
    assign bus.w_ready  = wr_open;

    assign rd_busy = bus.ar_ready || bus.r_valid;
    assign wr_busy = wr_open || bus.b_valid;
    assign rd_done = bus.ar_valid && bus.ar_ready;
    assign wr_done = bus.aw_valid && bus.aw_ready && bus.w_valid && bus.w_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // window check
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rd_word = {bus.ar_addr[ADDR_W-1:2], 2'b00};
    assign wr_word = {bus.aw_addr[ADDR_W-1:2], 2'b00};

    assign rd_ok = addr_aligned(bus.ar_addr, bus.ar_size) &&
                   (rd_word >= win_base) && (rd_word <= win_limit);
    assign wr_ok = addr_aligned(bus.aw_addr, bus.aw_size) &&
                   (wr_word >= win_base) && (wr_word <= win_limit);

    assign rd_idx = bus.ar_addr[SRAM_IDX_W+1:2];
    assign wr_idx = bus.aw_addr[SRAM_IDX_W+1:2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // channel control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // ready comes one cycle after valid; reads win if both arrive together.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.ar_ready <= 1'b0;
            bus.r_valid  <= 1'b0;
            wr_open      <= 1'b0;
            bus.b_valid  <= 1'b0;
        end else begin
            if (rd_done) begin
                bus.ar_ready <= 1'b0;
                bus.r_valid  <= 1'b1;
            end else if (bus.ar_valid && !rd_busy && !wr_busy) begin
                bus.ar_ready <= 1'b1;
            end
            if (bus.r_valid && bus.r_ready) begin
                bus.r_valid <= 1'b0;
            end

            if (wr_done) begin
                wr_open     <= 1'b0;
                bus.b_valid <= 1'b1;
            end else if (bus.aw_valid && bus.w_valid && !bus.ar_valid &&
                         !rd_busy && !wr_busy) begin
                wr_open <= 1'b1;
            end
            if (bus.b_valid && bus.b_ready) begin
                bus.b_valid <= 1'b0;
            end
        end
    end

    // array access and response payloads.
    always_ff @(posedge clk) begin
        if (rd_done) begin
            bus.r_data <= rd_ok ? mem[rd_idx] : '0;
            bus.r_resp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (wr_done) begin
            bus.b_resp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            for (int i = 0; i < 4; i++) begin
                if (wr_ok && bus.w_strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= bus.w_data[8*i +: 8];
                end
            end
        end
    end

    // a read counts as in flight from its address valid until its data is taken,
    // and a write likewise from its address or data valid until its response.
    a_one_open: assert property (@(posedge clk) disable iff (rst)
        !((bus.ar_valid || rd_busy) && (bus.aw_valid || bus.w_valid || wr_busy)));

endmodule

//--- design/mem_window_regs.sv
`timescale 1ns/1ns

module mem_window_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cfg_we,
    input  logic                       cfg_sel,
    input  logic [lsu_pkg::ADDR_W-1:0] cfg_wdata,
    output logic [lsu_pkg::ADDR_W-1:0] win_base,
    output logic [lsu_pkg::ADDR_W-1:0] win_limit
);
    import lsu_pkg::*;

    logic [ADDR_W-1:0] word_wdata;

    // both bounds are word addresses.
    assign word_wdata = {cfg_wdata[ADDR_W-1:2], 2'b00};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // window registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            win_base  <= WIN_RESET_BASE;
            win_limit <= WIN_RESET_LIMIT;
        end else if (cfg_we) begin
            case (cfg_sel)
                WIN_SEL_BASE: begin
                    win_base <= word_wdata;
                end
                WIN_SEL_LIMIT: begin
                    win_limit <= word_wdata;
                end
            endcase
        end
    end

    // the limit register is inclusive, so base == limit leaves one word open.

endmodule

//--- design/lsu_subsys_top.sv
`timescale 1ns/1ns

module lsu_subsys_top (
    input  logic                       clk,
    input  logic                       rst,
    // request from execute
    input  logic                       req_valid,
    input  lsu_pkg::mem_op_t           req_op,
    input  lsu_pkg::mem_size_t         req_size,
    input  logic                       req_signed,
    input  logic [lsu_pkg::ADDR_W-1:0] req_addr,
    input  logic [lsu_pkg::DATA_W-1:0] req_wdata,
    input  logic [lsu_pkg::TAG_W-1:0]  req_tag,
    output logic                       lsu_ready,
    // response to writeback
    output logic                       resp_valid,
    output logic [lsu_pkg::TAG_W-1:0]  resp_tag,
    output logic [lsu_pkg::DATA_W-1:0] resp_data,
    output logic                       resp_fault,
    // window configuration
    input  logic                       cfg_we,
    input  logic                       cfg_sel,
    input  logic [lsu_pkg::ADDR_W-1:0] cfg_wdata
);

    logic [lsu_pkg::ADDR_W-1:0] win_base;
    logic [lsu_pkg::ADDR_W-1:0] win_limit;

    mem_bus_if bus ();

    lsu u_lsu (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_size   (req_size),
        .req_signed (req_signed),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_tag    (req_tag),
        .lsu_ready  (lsu_ready),
        .resp_valid (resp_valid),
        .resp_tag   (resp_tag),
        .resp_data  (resp_data),
        .resp_fault (resp_fault),
        .bus        (bus.master)
    );

    data_sram u_sram (
        .clk       (clk),
        .rst       (rst),
        .win_base  (win_base),
        .win_limit (win_limit),
        .bus       (bus.slave)
    );

    mem_window_regs u_win (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_sel   (cfg_sel),
        .cfg_wdata (cfg_wdata),
        .win_base  (win_base),
        .win_limit (win_limit)
    );

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
    output logic clk,
    output logic rst
);

    // 8 ns period.
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // reset is held for the first eight rising edges.
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- bench/tb_lsu.sv
`timescale 1ns/1ns

module tb_lsu;
    import lsu_pkg::*;

    logic              clk;
    logic              rst;
    logic              req_valid;
    mem_op_t           req_op;
    mem_size_t         req_size;
    logic              req_signed;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic [TAG_W-1:0]  req_tag;
    logic              lsu_ready;
    logic              resp_valid;
    logic [TAG_W-1:0]  resp_tag;
    logic [DATA_W-1:0] resp_data;
    logic              resp_fault;
    logic              cfg_we;
    logic              cfg_sel;
    logic [ADDR_W-1:0] cfg_wdata;

    // model of the memory contents and of the window registers.
    logic [DATA_W-1:0] model_mem [SRAM_WORDS];
    logic [ADDR_W-1:0] model_base;
    logic [ADDR_W-1:0] model_limit;
    int                issued;
    int                cycles;

    clock_gen u_clk (.clk(clk), .rst(rst));

    lsu_subsys_top dut (.*);

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    // every request is allowed 20 cycles; the margin covers reset.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > 20 * issued + 200) begin
            report_failure($sformatf("timeout: the DUT stopped answering after %0d cycles", cycles));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic in_window(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] word;
        word = {addr[ADDR_W-1:2], 2'b00};
        return (word >= model_base) && (word <= model_limit);
    endfunction

    task automatic predict(input mem_op_t op, input mem_size_t size, input logic sgn,
                           input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                           output logic [DATA_W-1:0] exp_data, output logic exp_fault);
        logic [DATA_W-1:0] lane;
        int                idx;
        int                off;
        idx       = int'(addr[9:2]);
        off       = int'(addr[1:0]);
        exp_data  = '0;
        exp_fault = 1'b0;
        if (op == MEM_NONE) begin
            exp_data = addr;
        end else if (!in_window(addr)) begin
            exp_fault = 1'b1;
        end else if (op == MEM_STORE) begin
            for (int b = 0; b < (1 << int'(size)); b++) begin
                model_mem[idx][8*(off+b) +: 8] = wdata[8*b +: 8];
            end
        end else begin
            lane = model_mem[idx] >> (8 * off);
            case (size)
                SIZE_BYTE: exp_data = {{24{sgn & lane[7]}}, lane[7:0]};
                SIZE_HALF: exp_data = {{16{sgn & lane[15]}}, lane[15:0]};
                default:   exp_data = lane;
            endcase
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_request(input mem_op_t op, input mem_size_t size, input logic sgn,
                               input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] exp_data;
        logic              exp_fault;
        logic              got_resp;
        int                waited;
        tag = TAG_W'($urandom);
        predict(op, size, sgn, addr, wdata, exp_data, exp_fault);
        @(posedge clk);
        #1;
        while (!lsu_ready) begin
            @(posedge clk);
            #1;
        end
        req_valid  = 1'b1;
        req_op     = op;
        req_size   = size;
        req_signed = sgn;
        req_addr   = addr;
        req_wdata  = wdata;
        req_tag    = tag;
        issued++;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        waited    = 0;
        got_resp  = 1'b0;
        while (!got_resp) begin
            @(negedge clk);
            waited++;
            if (op != MEM_NONE) begin
                check_value("lsu_ready", lsu_ready, 32'd0);
            end
            got_resp = resp_valid;
        end
        if (op == MEM_NONE) begin
            check_value("resp_latency", waited, 32'd1);
        end
        check_value("resp_tag", resp_tag, tag);
        check_value("resp_fault", resp_fault, exp_fault);
        if (op != MEM_STORE) begin
            check_value("resp_data", resp_data, exp_data);
        end
    endtask

    task automatic write_window(input logic sel, input logic [ADDR_W-1:0] value);
        @(posedge clk);
        #1;
        cfg_we    = 1'b1;
        cfg_sel   = sel;
        cfg_wdata = value;
        issued++;
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
        if (sel == WIN_SEL_BASE) begin
            model_base = {value[ADDR_W-1:2], 2'b00};
        end else begin
            model_limit = {value[ADDR_W-1:2], 2'b00};
        end
    endtask

    // an aligned address in the memory, or now and then one far outside it.
    function automatic logic [ADDR_W-1:0] rand_addr(input mem_size_t size, input logic wild);
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] noise;
        noise = $urandom;
        if (wild && (noise[31:28] == 4'h0)) begin
            addr = {4'h1, noise[27:0]};
        end else begin
            addr = SRAM_BASE + {22'd0, noise[9:0]};
        end
        if (size == SIZE_HALF) begin
            addr[0] = 1'b0;
        end
        if (size == SIZE_WORD) begin
            addr[1:0] = 2'b00;
        end
        return addr;
    endfunction

    function automatic mem_size_t rand_size();
        mem_size_t size;
        case ($urandom_range(2))
            0:       size = SIZE_BYTE;
            1:       size = SIZE_HALF;
            default: size = SIZE_WORD;
        endcase
        return size;
    endfunction

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] wbase;
        mem_op_t           op;
        mem_size_t         size;
        void'($urandom(32'h76b3));
        req_valid  = 1'b0;
        req_op     = MEM_NONE;
        req_size   = SIZE_WORD;
        req_signed = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_tag    = '0;
        cfg_we     = 1'b0;
        cfg_sel    = 1'b0;
        cfg_wdata  = '0;
        issued     = 0;
        cycles     = 0;
        for (int i = 0; i < SRAM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        model_base  = WIN_RESET_BASE;
        model_limit = WIN_RESET_LIMIT;
        @(negedge rst);

        // word stores, each read back at once.
        for (int i = 0; i < 32; i++) begin
            addr = rand_addr(SIZE_WORD, 1'b0);
            run_request(MEM_STORE, SIZE_WORD, 1'b0, addr, $urandom);
            run_request(MEM_LOAD, SIZE_WORD, 1'b0, addr, '0);
        end

        // narrow stores at every offset, then narrow loads of both signedness.
        for (int i = 0; i < 4; i++) begin
            wbase = rand_addr(SIZE_WORD, 1'b0);
            run_request(MEM_STORE, SIZE_WORD, 1'b0, wbase, $urandom);
            for (int off = 0; off < 4; off++) begin
                run_request(MEM_STORE, SIZE_BYTE, 1'b0, wbase + 32'(off), $urandom);
                run_request(MEM_LOAD, SIZE_WORD, 1'b0, wbase, '0);
            end
            for (int off = 0; off < 4; off += 2) begin
                run_request(MEM_STORE, SIZE_HALF, 1'b0, wbase + 32'(off), $urandom);
                run_request(MEM_LOAD, SIZE_WORD, 1'b0, wbase, '0);
            end
            for (int off = 0; off < 8; off++) begin
                run_request(MEM_LOAD, SIZE_BYTE, 1'(off / 4), wbase + 32'(off % 4), '0);
            end
            for (int off = 0; off < 4; off++) begin
                run_request(MEM_LOAD, SIZE_HALF, 1'(off / 2), wbase + 32'(2 * (off % 2)), '0);
            end
        end

        for (int i = 0; i < 8; i++) begin
            run_request(MEM_NONE, rand_size(), 1'b0, $urandom, $urandom);
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // narrowed window
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        write_window(WIN_SEL_BASE, SRAM_BASE + 32'h100);
        write_window(WIN_SEL_LIMIT, SRAM_BASE + 32'h1FF);
        run_request(MEM_STORE, SIZE_WORD, 1'b0, SRAM_BASE + 32'h0FC, $urandom);
        run_request(MEM_LOAD, SIZE_WORD, 1'b0, SRAM_BASE + 32'h0FC, '0);
        run_request(MEM_STORE, SIZE_WORD, 1'b0, SRAM_BASE + 32'h200, $urandom);
        run_request(MEM_STORE, SIZE_WORD, 1'b0, SRAM_BASE + 32'h1FC, $urandom);
        run_request(MEM_LOAD, SIZE_WORD, 1'b0, SRAM_BASE + 32'h1FC, '0);
        for (int i = 0; i < 20; i++) begin
            size = rand_size();
            op   = ($urandom_range(1) == 0) ? MEM_LOAD : MEM_STORE;
            run_request(op, size, 1'($urandom_range(1)), rand_addr(size, 1'b1), $urandom);
        end
        write_window(WIN_SEL_BASE, WIN_RESET_BASE);
        write_window(WIN_SEL_LIMIT, WIN_RESET_LIMIT);
        run_request(MEM_LOAD, SIZE_WORD, 1'b0, SRAM_BASE + 32'h0FC, '0);
        run_request(MEM_LOAD, SIZE_WORD, 1'b0, SRAM_BASE + 32'h200, '0);

        // random mix, with the window moved now and then.
        for (int i = 0; i < 400; i++) begin
            if ($urandom_range(39) == 0) begin
                wbase = SRAM_BASE + {22'd0, 8'($urandom), 2'b00};
                write_window(WIN_SEL_BASE, wbase | 32'($urandom_range(3)));
                write_window(WIN_SEL_LIMIT, wbase + 32'($urandom_range(1023)));
            end
            case ($urandom_range(3))
                0:       op = MEM_NONE;
                1:       op = MEM_LOAD;
                default: op = MEM_STORE;
            endcase
            size = rand_size();
            addr = (op == MEM_NONE) ? $urandom : rand_addr(size, 1'b1);
            run_request(op, size, 1'($urandom_range(1)), addr, $urandom);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- sources.f
design/lsu_pkg.sv
design/mem_bus_if.sv
design/lsu.sv
design/data_sram.sv
design/mem_window_regs.sv
design/lsu_subsys_top.sv
bench/clock_gen.sv
bench/tb_lsu.sv

//--- Makefile
SIM      = verilator
TOP      = tb_lsu
FILELIST = sources.f
VFLAGS   = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
